// File: files.f
verilog/vmask_pkg.sv
verilog/popcount8.sv
verilog/first_one_encoder.sv
verilog/mask_unit.sv
verilog/mask_exec.sv
verilog/vreg_arbiter.sv
verilog/mask_regfile.sv
verilog/vmask_top.sv
testbench/tb_vmask.sv

// File: run_sim.sh
#!/bin/sh
# build the vmask testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_vmask -Mdir obj_dir -o sim_vmask \
  -f files.f

# tee keeps the log even when the simulation exits with an error
./obj_dir/sim_vmask | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

// File: testbench/tb_vmask.sv
// vmask testbench drives random mask commands and host traffic against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_vmask
  import vmask_pkg::*;
();

  localparam int CLK_HALF        = 50;                    // 100 ns clock
  localparam int CMD_CYCLES      = 40;                    // budget per command
  localparam int N_CMDS          = 40;                    // upper bound on commands run
  localparam int SETUP_CYCLES    = 400;                   // reset, loads, readbacks
  localparam int WATCHDOG_CYCLES = N_CMDS * CMD_CYCLES + SETUP_CYCLES;

  logic              clk;
  logic              rst_n;
  logic              cmd_valid;
  mask_cmd_t         cmd;
  logic              busy;
  logic              done;
  logic [XLEN-1:0]   scalar_result;
  logic              host_wr;
  logic              host_rd;
  logic [REG_AW-1:0] host_addr;
  logic [XLEN-1:0]   host_wdata;
  logic [XLEN-1:0]   host_rdata;

  logic [XLEN-1:0]   shadow [NREGS];   // expected register file contents
  logic [31:0]       rng_state;
  int                cmd_count;

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  vmask_top i_vmask_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_valid     (cmd_valid),
    .cmd           (cmd),
    .busy          (busy),
    .done          (done),
    .scalar_result (scalar_result),
    .host_wr       (host_wr),
    .host_rd       (host_rd),
    .host_addr     (host_addr),
    .host_wdata    (host_wdata),
    .host_rdata    (host_rdata)
  );

  // ****************************************
  // random numbers and reference model
  // ****************************************
  function automatic logic [31:0] rand32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // lowest index active in both vs2 and the mask, -1 if none
  function automatic int first_active(logic [XLEN-1:0] vs2, logic [XLEN-1:0] m);
    int pos;
    pos = -1;
    for (int i = 0; i < XLEN; i++) begin
      if (pos < 0 && vs2[i] && m[i])
        pos = i;
    end
    return pos;
  endfunction

  function automatic logic [XLEN-1:0] ref_result(mask_cmd_t c, logic [XLEN-1:0] m,
                                                  logic [XLEN-1:0] vs2, logic [XLEN-1:0] vs1);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] r;
    int              pos;
    int              anchor;
    int              cnt;
    a      = c.in_inv ? ~vs1 : vs1;
    pos    = first_active(vs2, m);
    anchor = (pos < 0) ? 0 : pos;      // empty search anchors at element 0
    cnt    = 0;
    r      = '0;
    for (int i = 0; i < XLEN; i++) begin
      if (vs2[i] && m[i])
        cnt++;
    end
    case (c.op)
      VMASK_AND   : r = vs2 & a;
      VMASK_OR    : r = vs2 | a;
      VMASK_XOR   : r = vs2 ^ a;
      VMASK_POPC  : r = XLEN'(cnt);
      VMASK_FIRST : r = (pos < 0) ? '1 : XLEN'(pos);
      VMASK_SBF   : for (int i = 0; i < XLEN; i++) r[i] = (i < anchor);
      VMASK_SIF   : for (int i = 0; i < XLEN; i++) r[i] = (i <= anchor);
      VMASK_SOF   : for (int i = 0; i < XLEN; i++) r[i] = (i == anchor);
      default     : r = '0;
    endcase
    if (c.out_inv && (c.op == VMASK_AND || c.op == VMASK_OR || c.op == VMASK_XOR))
      r = ~r;                          // only the logical ops invert
    return r;
  endfunction

  // iota element k counts active bits strictly below k
  function automatic logic [XLEN-1:0] ref_iota(logic [XLEN-1:0] vs2, logic [XLEN-1:0] m,
                                                int k);
    int cnt;
    cnt = 0;
    for (int i = 0; i < k; i++) begin
      if (vs2[i] && m[i])
        cnt++;
    end
    return XLEN'(cnt);
  endfunction

  function automatic mask_cmd_t rand_cmd(mask_op_e op);
    mask_cmd_t   c;
    logic [31:0] r;
    r         = rand32();
    c.op      = op;
    c.vd      = r[4:0];
    c.vs1     = r[9:5];
    c.vs2     = r[14:10];
    c.vm      = r[15];
    c.in_inv  = r[16];                 // ignored by the non logical ops
    c.out_inv = r[17];
    return c;
  endfunction

  // registers a command reads or writes, host traffic keeps off them
  function automatic bit touches(mask_cmd_t c, logic [REG_AW-1:0] addr);
    int span;
    bit hit;
    span = (c.op == VMASK_IOTA) ? IOTA_ELEMS : 1;
    hit  = (addr == '0) || (addr == c.vs1) || (addr == c.vs2);
    for (int k = 0; k < span; k++) begin
      if (addr == c.vd + REG_AW'(k))
        hit = 1'b1;
    end
    return hit;
  endfunction

  // ****************************************
  // checks
  // ****************************************
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (act !== exp)
      fail_run($sformatf("FAIL t=%0t %s expected %08h got %08h", $time, name, exp, act));
  endtask

  task automatic check_scalar(input logic [XLEN-1:0] exp);
    if (scalar_result !== exp)
      fail_run($sformatf("FAIL t=%0t scalar_result expected %08h got %08h",
                         $time, exp, scalar_result));
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp)
      fail_run($sformatf("FAIL t=%0t %s expected %b got %b", $time, name, exp, act));
  endtask

  // ****************************************
  // host port
  // ****************************************
  task automatic write_reg(input logic [REG_AW-1:0] addr, input logic [XLEN-1:0] data);
    @(posedge clk);
    host_wr      <= 1'b1;
    host_addr    <= addr;
    host_wdata   <= data;
    @(posedge clk);
    host_wr      <= 1'b0;
    shadow[addr] = data;
  endtask

  task automatic read_check(input logic [REG_AW-1:0] addr, input logic [XLEN-1:0] exp);
    @(posedge clk);
    host_rd   <= 1'b1;
    host_addr <= addr;
    @(posedge clk);
    host_rd   <= 1'b0;
    @(negedge clk);                    // data one cycle after the strobe
    check_word($sformatf("host_rdata v%0d", addr), exp, host_rdata);
  endtask

  // ****************************************
  // command sequencing
  // ****************************************
  // random host traffic while busy stalls exec in whichever state it sits
  task automatic wait_done(input mask_cmd_t c, input bit contend, input bit poke);
    int                cycles;
    int                window;         // cycles open to host traffic
    bit                seen;
    bit                rd_now;
    bit                rd_prev;        // host read from the previous cycle returns now
    logic [XLEN-1:0]   exp_now;
    logic [XLEN-1:0]   exp_prev;
    logic [31:0]       r;
    logic [31:0]       d;
    logic [REG_AW-1:0] a;
    mask_cmd_t         ghost;
    cycles   = 0;
    seen     = 1'b0;
    rd_prev  = 1'b0;
    exp_prev = '0;
    ghost    = c;
    ghost.vd = c.vd + REG_AW'(16);
    window   = contend ? CMD_CYCLES / 2 : 0;
    while (!seen) begin
      @(posedge clk);
      cmd_valid <= poke && (cycles == 1);  // extra strobe while busy
      if (poke && cycles == 1)
        cmd <= ghost;
      host_wr <= 1'b0;
      host_rd <= 1'b0;
      rd_now  = 1'b0;
      exp_now = '0;
      if (cycles < window) begin
        r = rand32();
        a = r[12:8];
        if (r[1] && !touches(c, a)) begin  // quiet cycles let exec through
          host_addr <= a;
          if (r[0]) begin
            d = rand32();
            host_wr    <= 1'b1;
            host_wdata <= d;
            shadow[a]  = d;
          end else begin
            host_rd <= 1'b1;
            rd_now  = 1'b1;
            exp_now = shadow[a];
          end
        end
      end
      @(negedge clk);
      if (rd_prev)
        check_word("host_rdata", exp_prev, host_rdata);
      rd_prev  = rd_now;
      exp_prev = exp_now;
      if (cycles == 0)
        check_level("busy", 1'b1, busy);
      seen = done;
      cycles++;
      if (!seen && cycles >= CMD_CYCLES)
        fail_run($sformatf("no done pulse within %0d cycles of an accepted command",
                           CMD_CYCLES));
    end
    @(posedge clk);
    cmd_valid <= 1'b0;
    host_wr   <= 1'b0;
    host_rd   <= 1'b0;
    @(negedge clk);
    if (rd_prev)
      check_word("host_rdata", exp_prev, host_rdata);
    check_level("done", 1'b0, done);   // single cycle pulse
    check_level("busy", 1'b0, busy);
  endtask

  task automatic run_cmd(input mask_cmd_t c, input bit contend, input bit poke);
    logic [XLEN-1:0]   m;
    logic [XLEN-1:0]   vs2;
    logic [XLEN-1:0]   vs1;
    logic [XLEN-1:0]   exp;
    logic [XLEN-1:0]   iota_exp [IOTA_ELEMS];
    logic [REG_AW-1:0] addr;
    logic [REG_AW-1:0] ghost_addr;
    m          = c.vm ? '1 : shadow[0];
    vs2        = shadow[c.vs2];
    vs1        = shadow[c.vs1];
    exp        = ref_result(c, m, vs2, vs1);
    ghost_addr = c.vd + REG_AW'(16);
    for (int k = 0; k < IOTA_ELEMS; k++)
      iota_exp[k] = ref_iota(vs2, m, k);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= c;
    wait_done(c, contend, poke);
    cmd_count++;
    if (poke) begin
      repeat (12) begin                // dropped strobe must not start a second run
        @(negedge clk);
        check_level("done", 1'b0, done);
        check_level("busy", 1'b0, busy);
      end
    end
    if (c.op == VMASK_IOTA) begin
      for (int k = 0; k < IOTA_ELEMS; k++) begin
        addr         = c.vd + REG_AW'(k);  // wraps past v31
        shadow[addr] = iota_exp[k];
      end
      for (int k = 0; k < IOTA_ELEMS; k++)
        read_check(c.vd + REG_AW'(k), iota_exp[k]);
    end else begin
      shadow[c.vd] = exp;
      read_check(c.vd, exp);
      if (c.op == VMASK_POPC || c.op == VMASK_FIRST)
        check_scalar(exp);
    end
    if (poke)
      read_check(ghost_addr, shadow[ghost_addr]);
  endtask

  // ****************************************
  // main sequence
  // ****************************************
  initial begin
    mask_op_e  logic_ops [3];
    mask_op_e  scal_ops [2];
    mask_op_e  set_ops [3];
    mask_cmd_t c;
    logic_ops  = '{VMASK_AND, VMASK_OR, VMASK_XOR};
    scal_ops   = '{VMASK_POPC, VMASK_FIRST};
    set_ops    = '{VMASK_SBF, VMASK_SIF, VMASK_SOF};
    rng_state  = 32'd69;
    cmd_count  = 0;
    rst_n      = 1'b0;
    cmd_valid  = 1'b0;
    cmd        = '0;
    host_wr    = 1'b0;
    host_rd    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_level("busy", 1'b0, busy);
    check_level("done", 1'b0, done);
    check_scalar('0);

    for (int i = 0; i < NREGS; i++)
      write_reg(REG_AW'(i), rand32());
    for (int i = 0; i < NREGS; i++)
      read_check(REG_AW'(i), shadow[i]);

    // logical ops, all inversion combinations
    for (int i = 0; i < 3; i++) begin
      for (int inv = 0; inv < 4; inv++) begin
        c         = rand_cmd(logic_ops[i]);
        c.in_inv  = inv[0];
        c.out_inv = inv[1];
        run_cmd(c, 1'b0, 1'b0);
      end
    end

    // popc and first, masked and unmasked, then an empty v0
    for (int vm = 0; vm < 2; vm++) begin
      for (int i = 0; i < 2; i++) begin
        c    = rand_cmd(scal_ops[i]);
        c.vm = vm[0];
        run_cmd(c, 1'b0, 1'b0);
      end
    end
    for (int i = 0; i < 2; i++) begin
      write_reg('0, '0);
      c    = rand_cmd(scal_ops[i]);
      c.vm = 1'b0;
      c.vd = REG_AW'(9);
      run_cmd(c, 1'b0, 1'b0);
    end
    write_reg('0, rand32());

    // sbf/sif/sof on random data, empty vs2 and a lone top bit
    for (int i = 0; i < 3; i++)
      run_cmd(rand_cmd(set_ops[i]), 1'b0, 1'b0);
    for (int i = 0; i < 3; i++) begin
      write_reg(REG_AW'(7), '0);
      c     = rand_cmd(set_ops[i]);
      c.vs2 = REG_AW'(7);
      c.vd  = REG_AW'(8);
      c.vm  = 1'b1;
      run_cmd(c, 1'b0, 1'b0);
    end
    for (int i = 0; i < 3; i++) begin
      write_reg(REG_AW'(7), 32'h8000_0000);
      c     = rand_cmd(set_ops[i]);
      c.vs2 = REG_AW'(7);
      c.vd  = REG_AW'(8);
      c.vm  = 1'b1;
      run_cmd(c, 1'b0, 1'b0);
    end

    // iota, second run wraps from v28 to v3
    c    = rand_cmd(VMASK_IOTA);
    c.vm = 1'b0;
    run_cmd(c, 1'b0, 1'b0);
    c    = rand_cmd(VMASK_IOTA);
    c.vd = REG_AW'(28);
    run_cmd(c, 1'b0, 1'b0);

    // host traffic while busy
    for (int i = 0; i < 6; i++) begin
      c = rand_cmd(mask_op_e'(4'(rand32() % 32'd9)));
      run_cmd(c, 1'b1, 1'b0);
    end

    // strobe while busy is ignored
    run_cmd(rand_cmd(VMASK_XOR), 1'b0, 1'b1);

    repeat (4) @(posedge clk);
    $display("%0d commands checked", cmd_count);
    $display("TESTS PASSED");
    $finish;
  end

  // ****************************************
  // watchdog
  // ****************************************
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule

`default_nettype wire

// File: verilog/first_one_encoder.sv
// first_one_encoder: index of the lowest bit set in both in and ena, with found strobe
`timescale 1ns/1ps
`default_nettype none

module first_one_encoder
  import vmask_pkg::*;
(
  input  wire logic [XLEN-1:0] in,
  input  wire logic [XLEN-1:0] ena,
  output logic                 strobe,  // 0: no enabled bit set
  output logic [4:0]           out
);

  logic [XLEN-1:0] hits;

  assign hits = in & ena;  // only active elements count

  // scan from the top down so the lowest hit is the last one written
  always_comb begin
    strobe = 1'b0;
    out    = '0;     // stays zero when nothing hits
    for (int i = XLEN - 1; i >= 0; i--) begin
      if (hits[i]) begin
        strobe = 1'b1;
        out    = 5'(i);
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/mask_exec.sv
// mask_exec: sequences one mask command, operand reads, iota loop and result writes
`timescale 1ns/1ps
`default_nettype none

module mask_exec
  import vmask_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            cmd_valid,
  input  wire mask_cmd_t       cmd,
  output logic                 busy,
  output logic                 done,
  output logic [XLEN-1:0]      scalar_result,
  output vreg_req_t            exec_req,
  output logic                 exec_req_valid,
  input  wire logic            exec_gnt,
  input  wire logic [XLEN-1:0] rdata
);

  exec_state_e     state, state_nxt;
  exec_state_e     rd_sel;        // state that issued the read now returning
  logic            rd_ack;        // rdata holds our read this cycle
  mask_cmd_t       cmd_q;
  logic [XLEN-1:0] mask_q, vs2_q, vs1_q;
  logic [XLEN-1:0] iota_bits;     // vs2 under the mask
  logic [XLEN-1:0] iota_cnt;      // set bits below the current element
  logic [IOTA_IW-1:0] iota_idx;
  logic            cmd_accept;
  logic            iota_last;
  logic            wr_phase;      // a write state, exec_req carries data
  mask_operands_t  operands;
  logic [XLEN-1:0] wdata_m;

  assign cmd_accept = cmd_valid && !busy;   // strobes while busy are dropped
  assign busy       = (state != EX_IDLE);
  assign done       = (state == EX_DONE);
  assign iota_bits  = vs2_q & mask_q;
  assign iota_last  = (iota_idx == IOTA_IW'(IOTA_ELEMS - 1));
  assign wr_phase   = (state == EX_WRITE) || (state == EX_IOTA_WR);

  // ****************************************
  // request to the arbiter
  // ****************************************
  always_comb begin
    exec_req.we    = wr_phase;
    exec_req.wdata = wr_phase ? wdata_m : '0;   // reads hold a quiet data field
    case (state)
      EX_RD_MASK : exec_req.addr = '0;                               // v0
      EX_RD_VS2  : exec_req.addr = cmd_q.vs2;
      EX_RD_VS1  : exec_req.addr = cmd_q.vs1;
      EX_WRITE   : exec_req.addr = cmd_q.vd;
      EX_IOTA_WR : exec_req.addr = cmd_q.vd + REG_AW'(iota_idx);     // wraps mod 32
      default    : exec_req.addr = '0;
    endcase
    case (state)
      EX_RD_MASK, EX_RD_VS2, EX_RD_VS1 : exec_req_valid = 1'b1;
      EX_WRITE, EX_IOTA_WR             : exec_req_valid = !rd_ack;   // last operand lands first
      default                          : exec_req_valid = 1'b0;
    endcase
  end

  always_comb begin
    state_nxt = state;
    case (state)
      EX_IDLE    : if (cmd_accept) state_nxt = EX_RD_MASK;
      EX_RD_MASK : if (exec_gnt) state_nxt = EX_RD_VS2;
      EX_RD_VS2  : if (exec_gnt) state_nxt = (cmd_q.op == VMASK_IOTA) ? EX_IOTA_WR : EX_RD_VS1;
      EX_RD_VS1  : if (exec_gnt) state_nxt = EX_WRITE;
      EX_WRITE   : if (exec_gnt) state_nxt = EX_DONE;
      EX_IOTA_WR : if (exec_gnt && iota_last) state_nxt = EX_DONE;
      EX_DONE    : state_nxt = EX_IDLE;          // one cycle done pulse
      default    : state_nxt = EX_IDLE;
    endcase
  end

  // ****************************************
  // control state
  // ****************************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state         <= EX_IDLE;
      rd_ack        <= 1'b0;
      scalar_result <= '0;
      iota_idx      <= '0;
      iota_cnt      <= '0;
    end else begin
      state  <= state_nxt;
      rd_ack <= exec_req_valid && exec_gnt && !exec_req.we;
      if (cmd_accept) begin
        iota_idx <= '0;
        iota_cnt <= '0;
      end
      if ((state == EX_IOTA_WR) && exec_gnt) begin
        iota_idx <= iota_idx + 1'b1;
        iota_cnt <= iota_cnt + XLEN'(iota_bits[iota_idx]);  // add bit k after writing k
      end
      if ((state == EX_WRITE) && exec_gnt &&
          ((cmd_q.op == VMASK_POPC) || (cmd_q.op == VMASK_FIRST)))
        scalar_result <= wdata_m;
    end
  end

  // command and operand payload
  always_ff @(posedge clk) begin
    if (cmd_accept) cmd_q <= cmd;
    rd_sel <= state;
    if (rd_ack) begin
      case (rd_sel)
        EX_RD_MASK : mask_q <= cmd_q.vm ? '1 : rdata;  // unmasked ignores v0
        EX_RD_VS2  : vs2_q  <= rdata;
        EX_RD_VS1  : vs1_q  <= rdata;
        default    : ;
      endcase
    end
  end

  // ****************************************
  // datapath
  // ****************************************
  assign operands.vs1_data   = vs1_q;
  assign operands.vs2_data   = vs2_q;
  assign operands.mask_32bit = mask_q;
  assign operands.op         = cmd_q.op;
  assign operands.in_inv     = cmd_q.in_inv;
  assign operands.out_inv    = cmd_q.out_inv;
  assign operands.iota_res   = iota_cnt;

  mask_unit i_mask_unit (
    .operands (operands),
    .wdata_m  (wdata_m)
  );

  // a stalled request stays put until the arbiter grants it
  assert property (@(posedge clk) disable iff (!rst_n)
    exec_req_valid && !exec_gnt |=> exec_req_valid && $stable(exec_req))
    else $error("exec request changed without grant");

  // an accepted command moves on to its reads and shows no done yet
  assert property (@(posedge clk) disable iff (!rst_n) cmd_accept |=> busy && !done)
    else $error("accepted command did not start its operand reads");

endmodule

`default_nettype wire

// File: verilog/mask_regfile.sv
// mask_regfile: single port 32x32 vector mask register file, registered read
`timescale 1ns/1ps
`default_nettype none

module mask_regfile
  import vmask_pkg::*;
(
  input  wire logic            clk,
  input  wire vreg_req_t       mem_req,
  input  wire logic            mem_valid,
  output logic [XLEN-1:0]      rdata
);

  logic [XLEN-1:0] mem [NREGS];  // one mask register per entry

  // ****************************************
  // port
  // ****************************************
  always_ff @(posedge clk) begin
    if (mem_valid) begin
      if (mem_req.we) begin
        mem[mem_req.addr] <= mem_req.wdata;  // lands on this edge
      end else begin
        rdata <= mem[mem_req.addr];          // visible next cycle
      end
    end
  end

  // rdata holds the last read while the port idles or writes

endmodule

`default_nettype wire

// File: verilog/mask_unit.sv
// mask_unit: combinational mask datapath, logical ops, popc, first, sbf/sif/sof and iota
`timescale 1ns/1ps
`default_nettype none

module mask_unit
  import vmask_pkg::*;
(
  input  wire mask_operands_t  operands,
  output logic [XLEN-1:0]      wdata_m
);

  logic [XLEN-1:0] vs1_adj;      // vs1 after optional inversion
  logic [XLEN-1:0] logic_res;    // vs2 op vs1_adj
  logic [XLEN-1:0] active;       // vs2 bits under the mask
  logic [XLEN-1:0] first_elem;
  logic [4:0]      enc_idx;
  logic            enc_found;
  logic [4:0]      pc0, pc1, pc2, pc3;
  logic [5:0]      popc_sum;
  logic [5:0]      sif_amt;      // one wider, index 31 shifts everything out

  assign vs1_adj  = operands.in_inv ? ~operands.vs1_data : operands.vs1_data;
  assign active   = operands.vs2_data & operands.mask_32bit;
  assign popc_sum = 6'(pc0) + 6'(pc1) + 6'(pc2) + 6'(pc3);
  assign sif_amt  = {1'b0, enc_idx} + 6'd1;
  assign first_elem = enc_found ? XLEN'(enc_idx) : '1;  // -1 when nothing set

  // ****************************************
  // search and count
  // ****************************************
  first_one_encoder i_first_one_encoder (
    .in     (operands.vs2_data),
    .ena    (operands.mask_32bit),
    .strobe (enc_found),
    .out    (enc_idx)
  );

  popcount8 i_popcount8_0 (.add_in(active[7:0]),   .add_out(pc0));
  popcount8 i_popcount8_1 (.add_in(active[15:8]),  .add_out(pc1));
  popcount8 i_popcount8_2 (.add_in(active[23:16]), .add_out(pc2));
  popcount8 i_popcount8_3 (.add_in(active[31:24]), .add_out(pc3));

  // ****************************************
  // result select
  // ****************************************
  always_comb begin
    case (operands.op)
      VMASK_AND : logic_res = operands.vs2_data & vs1_adj;
      VMASK_OR  : logic_res = operands.vs2_data | vs1_adj;
      default   : logic_res = operands.vs2_data ^ vs1_adj;  // xor
    endcase
  end

  always_comb begin
    case (operands.op)
      VMASK_AND,
      VMASK_OR,
      VMASK_XOR   : wdata_m = operands.out_inv ? ~logic_res : logic_res;
      VMASK_POPC  : wdata_m = XLEN'(popc_sum);
      VMASK_FIRST : wdata_m = first_elem;
      VMASK_SBF   : wdata_m = ~({XLEN{1'b1}} << enc_idx);  // empty gives 0
      VMASK_SIF   : wdata_m = ~({XLEN{1'b1}} << sif_amt);  // empty gives 1
      VMASK_SOF   : wdata_m = {{(XLEN-1){1'b0}}, 1'b1} << enc_idx;
      VMASK_IOTA  : wdata_m = operands.iota_res;           // count built in mask_exec
      default     : wdata_m = '0;
    endcase
  end

  // sbf/sif/sof rely on a zero index when the search comes up empty
  always_comb begin
    assert (enc_found || enc_idx == '0)
      else $error("first_one_encoder index %0d without strobe", enc_idx);
  end

endmodule

`default_nettype wire

// File: verilog/popcount8.sv
// popcount8: balanced adder tree counting the set bits of one byte
`timescale 1ns/1ps
`default_nettype none

module popcount8 (
  input  wire logic [7:0] add_in,
  output logic      [4:0] add_out
);

  logic [1:0] pair0, pair1, pair2, pair3;  // level 1, bit pairs
  logic [2:0] nib_lo, nib_hi;              // level 2, nibbles

  assign pair0 = {1'b0, add_in[0]} + {1'b0, add_in[1]};
  assign pair1 = {1'b0, add_in[2]} + {1'b0, add_in[3]};
  assign pair2 = {1'b0, add_in[4]} + {1'b0, add_in[5]};
  assign pair3 = {1'b0, add_in[6]} + {1'b0, add_in[7]};

  assign nib_lo = {1'b0, pair0} + {1'b0, pair1};  // max 4
  assign nib_hi = {1'b0, pair2} + {1'b0, pair3};

  // max 8 fits 4 bits, top bit stays zero
  assign add_out = {2'b00, nib_lo} + {2'b00, nib_hi};

endmodule

`default_nettype wire

// File: verilog/vmask_pkg.sv
// vmask package: sizes, opcode and FSM enums, command and register access structs
`default_nettype none

package vmask_pkg;

  // ****************************************
  // sizes
  // ****************************************
  localparam int XLEN       = 32;                 // register width, one bit per element
  localparam int NREGS      = 32;                 // vector registers in the file
  localparam int REG_AW     = 5;                  // register address width
  localparam int IOTA_ELEMS = 8;                  // iota elements written per command
  localparam int IOTA_IW    = $clog2(IOTA_ELEMS); // iota element counter width

  // ****************************************
  // enums
  // ****************************************
  typedef enum logic [3:0] {
    VMASK_AND   = 4'd0,
    VMASK_OR    = 4'd1,
    VMASK_XOR   = 4'd2,
    VMASK_POPC  = 4'd3,   // scalar result
    VMASK_FIRST = 4'd4,   // scalar result, all ones when empty
    VMASK_SBF   = 4'd5,
    VMASK_SIF   = 4'd6,
    VMASK_SOF   = 4'd7,
    VMASK_IOTA  = 4'd8    // multi register write
  } mask_op_e;

  // mask_exec sequencer states
  typedef enum logic [2:0] {
    EX_IDLE    = 3'd0,
    EX_RD_MASK = 3'd1,    // read v0
    EX_RD_VS2  = 3'd2,
    EX_RD_VS1  = 3'd3,
    EX_WRITE   = 3'd4,    // single result write to vd
    EX_IOTA_WR = 3'd5,    // IOTA_ELEMS writes from vd upward
    EX_DONE    = 3'd6
  } exec_state_e;

  // ****************************************
  // structs
  // ****************************************
  typedef struct packed {
    mask_op_e          op;
    logic [REG_AW-1:0] vd;
    logic [REG_AW-1:0] vs1;
    logic [REG_AW-1:0] vs2;
    logic              vm;       // 1: unmasked, all ones instead of v0
    logic              in_inv;   // invert vs1 before a logical op
    logic              out_inv;  // invert logical op result
  } mask_cmd_t;

  // one register file access, read when we is low
  typedef struct packed {
    logic              we;
    logic [REG_AW-1:0] addr;
    logic [XLEN-1:0]   wdata;
  } vreg_req_t;

  // operand set from mask_exec into the mask datapath
  typedef struct packed {
    logic [XLEN-1:0] vs1_data;
    logic [XLEN-1:0] vs2_data;
    logic [XLEN-1:0] mask_32bit;
    mask_op_e        op;
    logic            in_inv;
    logic            out_inv;
    logic [XLEN-1:0] iota_res;   // running count for the current iota element
  } mask_operands_t;

endpackage

`default_nettype wire

// File: verilog/vmask_top.sv
// vmask_top: mask execution subsystem, host port, mask_exec, arbiter and register file
`timescale 1ns/1ps
`default_nettype none

module vmask_top
  import vmask_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              cmd_valid,
  input  wire mask_cmd_t         cmd,
  output logic                   busy,
  output logic                   done,
  output logic [XLEN-1:0]        scalar_result,
  input  wire logic              host_wr,
  input  wire logic              host_rd,
  input  wire logic [REG_AW-1:0] host_addr,
  input  wire logic [XLEN-1:0]   host_wdata,
  output logic [XLEN-1:0]        host_rdata
);

  vreg_req_t       host_req, exec_req, mem_req;
  logic            host_req_valid, exec_req_valid, exec_gnt, mem_valid;
  logic [XLEN-1:0] rdata;   // shared read bus, host and exec

  // host pins into one access, write wins over read
  assign host_req.we    = host_wr;
  assign host_req.addr  = host_addr;
  assign host_req.wdata = host_wdata;
  assign host_req_valid = host_wr || host_rd;
  assign host_rdata     = rdata;

  mask_exec i_mask_exec (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_valid      (cmd_valid),
    .cmd            (cmd),
    .busy           (busy),
    .done           (done),
    .scalar_result  (scalar_result),
    .exec_req       (exec_req),
    .exec_req_valid (exec_req_valid),
    .exec_gnt       (exec_gnt),
    .rdata          (rdata)
  );

  vreg_arbiter i_vreg_arbiter (
    .host_req       (host_req),
    .host_req_valid (host_req_valid),
    .exec_req       (exec_req),
    .exec_req_valid (exec_req_valid),
    .exec_gnt       (exec_gnt),
    .mem_req        (mem_req),
    .mem_valid      (mem_valid)
  );

  mask_regfile i_mask_regfile (
    .clk       (clk),
    .mem_req   (mem_req),
    .mem_valid (mem_valid),
    .rdata     (rdata)
  );

endmodule

`default_nettype wire

// File: verilog/vreg_arbiter.sv
// vreg_arbiter: fixed priority arbiter, host before exec, onto the register file port
`timescale 1ns/1ps
`default_nettype none

module vreg_arbiter
  import vmask_pkg::*;
(
  input  wire vreg_req_t  host_req,
  input  wire logic       host_req_valid,
  input  wire vreg_req_t  exec_req,
  input  wire logic       exec_req_valid,
  output logic            exec_gnt,
  output vreg_req_t       mem_req,
  output logic            mem_valid
);

  // ****************************************
  // grant
  // ****************************************
  // host never waits, exec only gets idle cycles
  assign exec_gnt = exec_req_valid && !host_req_valid;

  // ****************************************
  // port mux
  // ****************************************
  always_comb begin
    if (host_req_valid) begin
      mem_req = host_req;       // host wins
    end else begin
      mem_req = exec_req;       // exec or idle
    end
  end

  assign mem_valid = host_req_valid || exec_req_valid;

  // two writers on one port, exec must lose every shared cycle
  always_comb begin
    if (host_req_valid) begin
      assert (!exec_gnt)
        else $error("exec granted alongside host access");
    end
  end

endmodule

`default_nettype wire
